/* compile.f */
design/mem_isa_pkg.sv
design/mem_bus_pkg.sv
design/store_formatter.sv
design/load_extender.sv
design/mem_handler.sv
design/data_ram.sv
design/mem_subsystem_top.sv
tb/mem_subsystem_chk.sv
tb/tb_mem_subsystem.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mem_subsystem \
    --Mdir obj_dir -o tb_mem_subsystem \
    -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_mem_subsystem
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi
exit 0

/* tb/tb_mem_subsystem.sv */
/*
 * Directed testbench for the memory subsystem, LATENCY 3 and 1024 words.
 * Plays the core with one job at a time; every access it issues is aligned.
 */
module tb_mem_subsystem
    import mem_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY     = 3;
    localparam int DEPTH_WORDS = 1024;
    localparam int N_WORDS     = 20;
    localparam int MAX_CYCLES  = 2000;   // ~100 jobs of 6 cycles plus reset, wide margin

    typedef enum {KIND_STORE, KIND_LOAD, KIND_FETCH} job_kind_e;

    logic        clk;
    logic        nrst;
    core_req_t   req;
    logic [31:0] pc;
    logic        fetch_en;
    logic [31:0] data_reg;
    logic [31:0] instruction;
    logic        store_done;
    logic        load_done;
    logic        fetch_done;

    logic [31:0] model [DEPTH_WORDS];   // expected RAM contents
    integer      seed;
    int          cycle_count;

    mem_subsystem_top #(
        .DEPTH_WORDS(DEPTH_WORDS),
        .LATENCY    (LATENCY)
    ) DUT (.*);

    // the top sees both handler and RAM and carries LATENCY
    bind mem_subsystem_top mem_subsystem_chk #(
        .LATENCY(LATENCY)
    ) u_chk (.*, .sample(u_handler.sample));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
                $display("Result: FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % DEPTH_WORDS);   // RAM wraps on depth
    endfunction

    // extension rule applied to a model word
    function automatic logic [31:0] expect_load(input logic [31:0] word, input logic [1:0] off,
                                                input mem_op_e op);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    // called at a drive point, returns at the next free drive point
    task automatic run_job(input core_req_t r, input logic fen, input job_kind_e kind);
        int   n;
        logic pulse;
        logic right;
        req      = r;
        fetch_en = fen;
        n        = 0;
        pulse    = 1'b0;
        while (!pulse) begin
            @(posedge clk);
            #1;
            n++;
            pulse = store_done | load_done | fetch_done;
        end
        case (kind)
            KIND_STORE: right = store_done && !load_done && !fetch_done;
            KIND_LOAD:  right = load_done && !store_done && !fetch_done;
            default:    right = fetch_done && !store_done && !load_done;
        endcase
        check_true(right, "a different done pulse than the expected one arrived");
        check_true(n == LATENCY + 2,
                   $sformatf("done pulse came %0d cycles after sampling, not %0d",
                             n, LATENCY + 2));
        req      = '0;
        fetch_en = 1'b0;
        pc       = '0;
        @(posedge clk);   // sampling is blocked during the pulse
        #1;
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                            input mem_op_e op, input logic fen);
        core_req_t r;
        int        idx;
        r       = '0;
        r.addr  = addr;
        r.rs1   = data;
        r.op    = op;
        r.write = 1'b1;
        run_job(r, fen, KIND_STORE);
        idx = word_index(addr);
        case (op)
            OP_SB:   model[idx][8*addr[1:0] +: 8] = data[7:0];
            OP_SH:   model[idx][16*addr[1] +: 16] = data[15:0];
            default: model[idx] = data;
        endcase
    endtask

    task automatic do_load(input logic [31:0] addr, input mem_op_e op);
        core_req_t r;
        r      = '0;
        r.addr = addr;
        r.op   = op;
        r.read = 1'b1;
        run_job(r, 1'b0, KIND_LOAD);
        check_equal("data_reg", expect_load(model[word_index(addr)], addr[1:0], op), data_reg);
    endtask

    task automatic test_reset();
        check_equal("store_done", 32'd0, 32'(store_done));
        check_equal("load_done", 32'd0, 32'(load_done));
        check_equal("fetch_done", 32'd0, 32'(fetch_done));
        check_equal("data_reg", 32'd0, data_reg);
        check_equal("instruction", 32'd0, instruction);
    endtask

    task automatic test_word_roundtrip();
        logic [31:0] addr;
        for (int i = 0; i < N_WORDS; i++) begin
            addr = $random(seed) & 32'hffff_fffc;
            do_store(addr, $random(seed), OP_SW, 1'b0);
            do_load(addr, OP_LW);
        end
    endtask

    task automatic test_byte_half();
        logic [31:0] base;
        for (int round = 0; round < 2; round++) begin
            base = $random(seed) & 32'hffff_fffc;
            do_store(base, $random(seed), OP_SW, 1'b0);
            for (int off = 0; off < 4; off++) begin
                do_store(base + off, $random(seed), OP_SB, 1'b0);
                do_load(base, OP_LW);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_store(base + off, $random(seed), OP_SH, 1'b0);
                do_load(base, OP_LW);
            end
        end
    endtask

    task automatic test_extension();
        logic [31:0] base;
        logic [31:0] word [2];
        base    = $random(seed) & 32'hffff_fffc;
        word[0] = $random(seed) | 32'h8080_8080;   // every field msb set
        word[1] = $random(seed) & 32'h7f7f_7f7f;   // every field msb clear
        for (int v = 0; v < 2; v++) begin
            do_store(base, word[v], OP_SW, 1'b0);
            for (int off = 0; off < 4; off++) begin
                do_load(base + off, OP_LB);
                do_load(base + off, OP_LBU);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_load(base + off, OP_LH);
                do_load(base + off, OP_LHU);
            end
        end
    endtask

    task automatic test_fetch();
        logic [31:0] addr;
        core_req_t   r;
        for (int i = 0; i < 4; i++) begin
            addr = $random(seed) & 32'hffff_fffc;
            pc   = addr;
            do_store(addr, $random(seed), OP_SW, 1'b1);   // write wins over fetch_en
            r      = '0;
            r.addr = ~addr;   // data address is ignored on a fetch
            pc     = addr;
            run_job(r, 1'b1, KIND_FETCH);
            check_equal("instruction", model[word_index(addr)], instruction);
        end
    endtask

    initial begin
        seed     = 32'h23a4;
        nrst     = 1'b0;
        req      = '0;
        pc       = '0;
        fetch_en = 1'b0;
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        nrst = 1'b1;
        @(posedge clk);
        #1;
        test_reset();
        test_word_roundtrip();
        test_byte_half();
        test_extension();
        test_fetch();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb/mem_subsystem_chk.sv */
/*
 * Concurrent checks on the handler and RAM, bound into the subsystem top.
 * Assumes one job in flight at a time.
 */
module mem_subsystem_chk
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int LATENCY = 3
) (
    input logic      clk,
    input logic      nrst,
    input logic      sample,
    input core_req_t req,
    input bus_req_t  bus_req,
    input logic      busy,
    input logic      store_done,
    input logic      load_done,
    input logic      fetch_done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic       any_done;
    logic       aligned;
    logic [3:0] age;      // cycles since the job was sampled
    logic [3:0] busy_len; // consecutive busy cycles

    assign any_done = store_done | load_done | fetch_done;
    // word needs offset 0, halfword an even offset
    assign aligned  = (req.op == OP_LW) ? (req.addr[1:0] == 2'd0)
                    : (req.op == OP_LH || req.op == OP_LHU) ? !req.addr[0] : 1'b1;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            age <= 4'd0;
        end else if (sample) begin
            age <= 4'd1;
        end else if (any_done) begin
            age <= 4'd0;
        end else if (age != 4'd0) begin
            age <= age + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy_len <= 4'd0;
        end else if (busy) begin
            busy_len <= busy_len + 4'd1;
        end else begin
            busy_len <= 4'd0;
        end
    end

    a_single_done: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({store_done, load_done, fetch_done}))
        else $error("several done pulses high together");

    a_write_be: assert property (@(posedge clk) disable iff (!nrst)
        bus_req.write |-> bus_req.be != 4'd0)
        else $error("bus write without byte enables");

    a_busy_len: assert property (@(posedge clk) disable iff (!nrst)
        (!busy && busy_len != 4'd0) |-> busy_len == 4'(LATENCY))
        else $error("RAM busy not held for LATENCY cycles");

    a_latency: assert property (@(posedge clk) disable iff (!nrst)
        any_done |-> age == 4'(LATENCY + 2))
        else $error("done pulse not LATENCY+2 cycles after sampling");

    a_aligned: assert property (@(posedge clk) disable iff (!nrst)
        (sample && (req.read || req.write)) |-> aligned)
        else $error("misaligned data access");

endmodule

/* design/mem_subsystem_top.sv */
/*
 * Memory-access subsystem: handler, store formatter, load extender and RAM.
 * Accesses must be aligned to their size. LATENCY 1..8, DEPTH_WORDS a power of two.
 */
module mem_subsystem_top
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int DEPTH_WORDS = 1024,
    parameter int LATENCY     = 3
) (
    input  logic        clk,
    input  logic        nrst,
    input  core_req_t   req,
    input  logic [31:0] pc,
    input  logic        fetch_en,
    output logic [31:0] data_reg,
    output logic [31:0] instruction,
    output logic        store_done,
    output logic        load_done,
    output logic        fetch_done
);

    mem_op_e     fmt_op;
    logic [1:0]  fmt_offset;
    logic [31:0] fmt_wdata;
    logic [3:0]  fmt_be;
    mem_op_e     ld_op;
    logic [1:0]  ld_offset;
    logic [31:0] ld_value;
    bus_req_t    bus_req;
    logic [31:0] rdata;
    logic        busy;
    logic        done;

    mem_handler #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) u_handler (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .pc         (pc),
        .fetch_en   (fetch_en),
        .fmt_wdata  (fmt_wdata),
        .fmt_be     (fmt_be),
        .ld_value   (ld_value),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .fmt_op     (fmt_op),
        .fmt_offset (fmt_offset),
        .ld_op      (ld_op),
        .ld_offset  (ld_offset),
        .bus_req    (bus_req),
        .data_reg   (data_reg),
        .instruction(instruction),
        .store_done (store_done),
        .load_done  (load_done),
        .fetch_done (fetch_done)
    );

    store_formatter u_fmt (
        .op    (fmt_op),
        .offset(fmt_offset),
        .rs1   (req.rs1),    // core holds rs1 with the write level
        .wdata (fmt_wdata),
        .be    (fmt_be)
    );

    load_extender u_ext (
        .op    (ld_op),
        .offset(ld_offset),
        .rdata (rdata),
        .value (ld_value)
    );

    data_ram #(
        .DEPTH_WORDS(DEPTH_WORDS),
        .LATENCY    (LATENCY)
    ) u_ram (
        .clk    (clk),
        .nrst   (nrst),
        .bus_req(bus_req),
        .rdata  (rdata),
        .busy   (busy),
        .done   (done)
    );

endmodule

/* design/data_ram.sv */
/*
 * Word RAM with byte enables and a fixed latency of LATENCY cycles (1..8).
 * busy is high for LATENCY cycles after a request is taken, done and rdata in
 * the last one. DEPTH_WORDS must be a power of two, at least 2. Contents start at zero.
 */
module data_ram
    import mem_bus_pkg::*;
#(
    parameter int DEPTH_WORDS = 1024,
    parameter int LATENCY     = 3
) (
    input  logic        clk,
    input  logic        nrst,
    input  bus_req_t    bus_req,
    output logic [31:0] rdata,
    output logic        busy,
    output logic        done
);

    localparam int AW = $clog2(DEPTH_WORDS);

    logic [31:0]   mem [DEPTH_WORDS];
    bus_req_t      req_q;        // request held over the latency
    logic [3:0]    cnt;          // cycles left
    logic          accept;
    logic [AW-1:0] idx;

    initial begin
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign busy   = (cnt != 4'd0);
    assign done   = (cnt == 4'd1);
    assign accept = (bus_req.read || bus_req.write) && !busy;
    assign idx    = req_q.addr[AW-1:0];
    assign rdata  = mem[idx];    // valid while done is high

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cnt <= 4'd0;
        end else if (accept) begin
            cnt <= 4'(LATENCY);
        end else if (busy) begin
            cnt <= cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= bus_req;
        end
    end

    // write lands in the final latency cycle
    always_ff @(posedge clk) begin
        if (done && req_q.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.be[b]) begin
                    mem[idx][8*b +: 8] <= req_q.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* design/mem_handler.sv */
/*
 * Store/load/fetch sequencer, one job in flight. Priority is write, read, fetch_en.
 * Core must hold read/write until its done pulse; no job is sampled while a
 * done pulse is high. DEPTH_WORDS must be a power of two (addresses wrap).
 */
module mem_handler
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic        clk,
    input  logic        nrst,
    input  core_req_t   req,
    input  logic [31:0] pc,
    input  logic        fetch_en,
    input  logic [31:0] fmt_wdata,
    input  logic [3:0]  fmt_be,
    input  logic [31:0] ld_value,
    input  logic [31:0] rdata,
    input  logic        busy,
    input  logic        done,
    output mem_op_e     fmt_op,
    output logic [1:0]  fmt_offset,
    output mem_op_e     ld_op,
    output logic [1:0]  ld_offset,
    output bus_req_t    bus_req,
    output logic [31:0] data_reg,
    output logic [31:0] instruction,
    output logic        store_done,
    output logic        load_done,
    output logic        fetch_done
);

    typedef enum logic [1:0] {
        JOB_STORE = 2'd0,
        JOB_LOAD  = 2'd1,
        JOB_FETCH = 2'd2
    } job_e;

    localparam logic [29:0] WRAP_MASK = 30'(DEPTH_WORDS - 1);

    hstate_e     state;
    job_e        job_q;
    mem_op_e     op_q;
    logic [1:0]  offset_q;
    logic [29:0] waddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  be_q;

    logic        pulse_any;
    logic        sample;
    logic        data_job;
    logic        issue_ok;

    assign pulse_any = store_done | load_done | fetch_done;
    assign data_job  = req.write | req.read;
    // a new job is taken only in IDLE and never during a done pulse
    assign sample    = (state == IDLE) && !pulse_any && (data_job || fetch_en);
    assign issue_ok  = (state == ISSUE) && !busy;

    // formatter sees the live request, its result is latched on sample
    assign fmt_op     = req.op;
    assign fmt_offset = req.addr[1:0];
    // extender works on the latched job
    assign ld_op      = op_q;
    assign ld_offset  = offset_q;

    always_comb begin
        bus_req.addr  = waddr_q;
        bus_req.wdata = wdata_q;
        bus_req.be    = be_q;
        bus_req.write = issue_ok && (job_q == JOB_STORE);
        bus_req.read  = issue_ok && (job_q != JOB_STORE);
    end

    // job payload
    always_ff @(posedge clk) begin
        if (sample) begin
            op_q     <= req.op;
            offset_q <= req.addr[1:0];
            if (data_job) begin
                waddr_q <= req.addr[31:2] & WRAP_MASK;
            end else begin
                waddr_q <= pc[31:2] & WRAP_MASK;   // fetch from pc
            end
            wdata_q <= fmt_wdata;
            if (req.write) begin
                be_q <= fmt_be;
            end else begin
                be_q <= 4'b1111;                   // reads take the whole word
            end
        end
    end

    // sequencer, results and done pulses
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= IDLE;
            job_q       <= JOB_FETCH;
            data_reg    <= '0;
            instruction <= '0;
            store_done  <= 1'b0;
            load_done   <= 1'b0;
            fetch_done  <= 1'b0;
        end else begin
            store_done <= 1'b0;   // pulses last one cycle
            load_done  <= 1'b0;
            fetch_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (sample) begin
                        state <= ISSUE;
                        if (req.write) begin
                            job_q <= JOB_STORE;
                        end else if (req.read) begin
                            job_q <= JOB_LOAD;
                        end else begin
                            job_q <= JOB_FETCH;
                        end
                    end
                end
                ISSUE: begin
                    if (!busy) begin
                        state <= WAIT;   // RAM accepts this cycle
                    end
                end
                WAIT: begin
                    if (done) begin
                        state <= IDLE;
                        case (job_q)
                            JOB_STORE: store_done <= 1'b1;
                            JOB_LOAD: begin
                                data_reg  <= ld_value;
                                load_done <= 1'b1;
                            end
                            default: begin
                                instruction <= rdata;   // raw word, no extension
                                fetch_done  <= 1'b1;
                            end
                        endcase
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* design/load_extender.sv */
/*
 * Picks the addressed byte or halfword from a RAM word and extends it.
 * Offset must be aligned to the access size. LW and unknown codes pass the word.
 */
module load_extender
    import mem_isa_pkg::*;
(
    input  mem_op_e     op,
    input  logic [1:0]  offset,
    input  logic [31:0] rdata,
    output logic [31:0] value
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane select
    always_comb begin
        case (offset)
            2'd0:    byte_lane = rdata[7:0];
            2'd1:    byte_lane = rdata[15:8];
            2'd2:    byte_lane = rdata[23:16];
            default: byte_lane = rdata[31:24];
        endcase
        if (offset[1]) begin
            half_lane = rdata[31:16];
        end else begin
            half_lane = rdata[15:0];
        end
    end

    // extension, sign taken from the field's own msb
    always_comb begin
        case (op)
            OP_LB:   value = {{24{byte_lane[7]}}, byte_lane};
            OP_LH:   value = {{16{half_lane[15]}}, half_lane};
            OP_LBU:  value = {24'd0, byte_lane};
            OP_LHU:  value = {16'd0, half_lane};
            default: value = rdata;              // LW
        endcase
    end

endmodule

/* design/store_formatter.sv */
/*
 * Places SB/SH/SW data on its byte lanes and builds the byte enables.
 * Offset must be aligned to the access size; other ops give no enables.
 */
module store_formatter
    import mem_isa_pkg::*;
(
    input  mem_op_e     op,
    input  logic [1:0]  offset,
    input  logic [31:0] rs1,
    output logic [31:0] wdata,
    output logic [3:0]  be
);

    always_comb begin
        case (op)
            OP_SB: begin
                wdata = {4{rs1[7:0]}};           // byte on every lane
                be    = 4'b0001 << offset;
            end
            OP_SH: begin
                wdata = {2{rs1[15:0]}};          // half on both halves
                if (offset[1]) begin
                    be = 4'b1100;
                end else begin
                    be = 4'b0011;
                end
            end
            OP_SW: begin
                wdata = rs1;
                be    = 4'b1111;
            end
            default: begin
                wdata = rs1;                     // not a store code
                be    = 4'b0000;
            end
        endcase
    end

endmodule

/* design/mem_bus_pkg.sv */
/*
 * RAM-side types. The bus carries word addresses only; byte placement is
 * expressed by the byte enables. At most one of read and write is high.
 */
package mem_bus_pkg;

    // request from the handler to the RAM, 68 bits
    typedef struct packed {
        logic [29:0] addr;    // word address, already wrapped to the RAM depth
        logic [31:0] wdata;   // lane-aligned store data
        logic [3:0]  be;      // byte enables, bit i covers wdata[8i+7:8i]
        logic        write;   // single-cycle write strobe
        logic        read;    // single-cycle read strobe
    } bus_req_t;

    // handler sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // sample core strobes
        ISSUE = 2'd1,   // present request to the RAM
        WAIT  = 2'd2    // wait for RAM done
    } hstate_e;

endpackage

/* design/mem_isa_pkg.sv */
/*
 * Core-side types of the memory unit. Opcodes are the RV32I funct3 width codes.
 * Store codes share values 0..2 with the signed loads, so they are constants
 * of the same enum type and not separate enum members.
 */
package mem_isa_pkg;

    // funct3 width codes for loads
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,   // signed byte
        OP_LH  = 3'd1,   // signed halfword
        OP_LW  = 3'd2,   // full word
        OP_LBU = 3'd4,   // unsigned byte
        OP_LHU = 3'd5    // unsigned halfword
    } mem_op_e;

    // store codes reuse the low three funct3 values
    localparam mem_op_e OP_SB = OP_LB;
    localparam mem_op_e OP_SH = OP_LH;
    localparam mem_op_e OP_SW = OP_LW;

    // request bundle from the core, 69 bits
    typedef struct packed {
        logic [31:0] addr;    // byte address of the data access
        logic [31:0] rs1;     // store data
        mem_op_e     op;      // funct3
        logic        read;    // load level, held until load_done
        logic        write;   // store level, held until store_done
    } core_req_t;

endpackage
